// File: Bender.yml
package:
  name: paillier_coproc

sources:
  - include_dirs:
      - source
    files:
      - source/paillier_pkg.sv
      - source/mod_mul_if.sv
      - source/mod_mul.sv
      - source/mod_exp.sv
      - source/operand_buffer.sv
      - source/task_ctrl.sv
      - source/paillier_top.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - sim/tb_checker.sv
      - sim/tb_paillier.sv

// File: filelist.f
+incdir+source
source/paillier_pkg.sv
source/mod_mul_if.sv
source/mod_mul.sv
source/mod_exp.sv
source/operand_buffer.sv
source/task_ctrl.sv
source/paillier_top.sv
sim/tb_checker.sv
sim/tb_paillier.sv

// File: sim/tb_checker.sv
`timescale 1ns/1ps
`include "paillier_defs.svh"

module tb_checker (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [1:0]        task_cmd,
    input  logic              task_req,
    input  logic              op_valid,
    input  logic [`KEY_W-1:0] op_a,
    input  logic [`KEY_W-1:0] op_b,
    input  logic [`KEY_W-1:0] result_data,
    input  logic              result_valid,
    input  logic              task_end,
    input  logic              busy,
    output logic [31:0]       error_count,
    output logic [31:0]       result_count,
    output logic [31:0]       cross_count
);
    import paillier_pkg::*;

    localparam logic [63:0] N2_WIDE = {32'd0, `MOD_N2};

    logic [31:0] exp_q [$];
    logic [31:0] a_q [$];
    logic [31:0] b_q [$];
    // last encryption batch, kept for the homomorphic cross-check
    logic [31:0] enc_m [`BATCH_LEN];
    logic [31:0] enc_r [`BATCH_LEN];
    logic [31:0] enc_c [`BATCH_LEN];
    int          enc_fill = 0;
    task_cmd_e   cmd_q = cmd_encrypt;
    int          task_idx = 0;
    int          item_idx = 0;
    logic        busy_model = 1'b0;
    int          err_cnt = 0;
    int          res_cnt = 0;
    int          cross_cnt = 0;

    assign error_count  = err_cnt;
    assign result_count = res_cnt;
    assign cross_count  = cross_cnt;

    function automatic logic [31:0] mul_mod_n2(input logic [31:0] x, input logic [31:0] y);
        logic [63:0] p;
        p = {32'd0, x} * {32'd0, y};
        return 32'(p % N2_WIDE);
    endfunction

    // left to right over all 32 exponent bits
    function automatic logic [31:0] pow_mod_n2(input logic [31:0] base, input logic [31:0] e);
        logic [31:0] r;
        logic [31:0] b;
        int          i;
        r = 32'd1;
        b = 32'({32'd0, base} % N2_WIDE);
        for (i = 31; i >= 0; i--) begin
            r = mul_mod_n2(r, r);
            if (e[i]) begin
                r = mul_mod_n2(r, b);
            end
        end
        return r;
    endfunction

    function automatic logic [31:0] expected_result(input task_cmd_e cmd, input logic [31:0] a,
                                                    input logic [31:0] b);
        logic [31:0] mn_plus_one;
        case (cmd)
            cmd_encrypt: begin
                // g = n+1, so g^m = 1 + m*n
                mn_plus_one = mul_mod_n2(a, `MOD_N) + 32'd1;
                return mul_mod_n2(mn_plus_one, pow_mod_n2(b, `MOD_N));
            end
            cmd_homo_add:   return mul_mod_n2(a, b);
            cmd_scalar_mul: return pow_mod_n2(a, b);
            default:        return 32'd0;
        endcase
    endfunction

    function automatic string cmd_name(input task_cmd_e cmd);
        case (cmd)
            cmd_encrypt:    return "encrypt";
            cmd_homo_add:   return "homo_add";
            cmd_scalar_mul: return "scalar_mul";
            default:        return "reserved";
        endcase
    endfunction

    // E(m1)*E(m2) must equal E(m1+m2) with r = r1*r2
    task automatic check_cross(input logic [31:0] a, input logic [31:0] b,
                               input logic [31:0] actual);
        int          i;
        int          k;
        int          hit_i;
        int          hit_k;
        logic [31:0] m_sum;
        logic [31:0] want;
        hit_i = -1;
        hit_k = -1;
        for (i = 0; i < enc_fill; i++) begin
            for (k = 0; k < enc_fill; k++) begin
                if (hit_i < 0 && enc_c[i] == a && enc_c[k] == b) begin
                    hit_i = i;
                    hit_k = k;
                end
            end
        end
        if (hit_i >= 0) begin
            m_sum = (enc_m[hit_i] + enc_m[hit_k]) % `MOD_N;
            want  = expected_result(cmd_encrypt, m_sum, mul_mod_n2(enc_r[hit_i], enc_r[hit_k]));
            cross_cnt++;
            if (actual !== want) begin
                $display("mismatch homo_cross task %0d items %0d,%0d expected %h actual %h",
                         task_idx, hit_i, hit_k, want, actual);
                err_cnt++;
            end
        end
    endtask

    always @(posedge clk) begin : watch
        logic [31:0] want;
        logic [31:0] a;
        logic [31:0] b;
        logic        end_want;
        if (!rst_n) begin
            if (busy !== 1'b0 || result_valid !== 1'b0 || task_end !== 1'b0) begin
                $display("outputs were not idle during reset at %0t", $time);
                err_cnt++;
            end
            busy_model = 1'b0;
        end else begin
            if (busy !== busy_model) begin
                $display("mismatch %s_task%0d busy expected %b actual %b",
                         cmd_name(cmd_q), task_idx, busy_model, busy);
                err_cnt++;
            end
            if (!busy_model && (result_valid !== 1'b0 || task_end !== 1'b0)) begin
                $display("result_valid or task_end was high with no task running at %0t", $time);
                err_cnt++;
            end
            end_want = (result_valid === 1'b1) && (item_idx == `BATCH_LEN - 1);
            if (busy_model && task_end !== end_want) begin
                $display("mismatch %s_task%0d item %0d task_end expected %b actual %b",
                         cmd_name(cmd_q), task_idx, item_idx, end_want, task_end);
                err_cnt++;
            end
            if (result_valid === 1'b1) begin
                if (exp_q.size() == 0) begin
                    $display("a result arrived with no operand pair pending at %0t", $time);
                    err_cnt++;
                end else begin
                    want = exp_q.pop_front();
                    a    = a_q.pop_front();
                    b    = b_q.pop_front();
                    res_cnt++;
                    if (result_data !== want) begin
                        $display("mismatch %s_task%0d item %0d expected %h actual %h",
                                 cmd_name(cmd_q), task_idx, item_idx, want, result_data);
                        err_cnt++;
                    end
                    if (cmd_q == cmd_encrypt && item_idx < `BATCH_LEN) begin
                        enc_m[item_idx] = a;
                        enc_r[item_idx] = b;
                        enc_c[item_idx] = result_data;
                        enc_fill        = item_idx + 1;
                    end else if (cmd_q == cmd_homo_add) begin
                        check_cross(a, b, result_data);
                    end
                end
                item_idx++;
            end
            if (op_valid === 1'b1) begin
                exp_q.push_back(expected_result(cmd_q, op_a, op_b));
                a_q.push_back(op_a);
                b_q.push_back(op_b);
            end
            if (task_req === 1'b1) begin
                if (task_idx > 0 && item_idx != `BATCH_LEN) begin
                    $display("mismatch %s_task%0d result count expected %0d actual %0d",
                             cmd_name(cmd_q), task_idx, `BATCH_LEN, item_idx);
                    err_cnt++;
                end
                cmd_q    = task_cmd_e'(task_cmd);
                task_idx++;
                item_idx = 0;
                if (cmd_q == cmd_encrypt) begin
                    enc_fill = 0;
                end
                busy_model = 1'b1;
            end else if (task_end === 1'b1) begin
                busy_model = 1'b0;
            end
        end
    end

endmodule

// File: sim/tb_paillier.sv
`timescale 1ns/1ps
`include "paillier_defs.svh"

module tb_paillier;
    import paillier_pkg::*;

    localparam int CLK_PERIOD  = 4;
    localparam int NUM_TASKS   = 5;
    // square and multiply for every exponent bit, each about KEY_W+1 cycles
    localparam int ITEM_CYCLES = 4 * (`KEY_W + 1) * (`KEY_W + 1);
    localparam int TIMEOUT_NS  = 2 * NUM_TASKS * `BATCH_LEN * (ITEM_CYCLES + 4) * CLK_PERIOD;

    logic              clk;
    logic              rst_n;
    logic [1:0]        task_cmd;
    logic              task_req;
    logic              op_valid;
    logic [`KEY_W-1:0] op_a;
    logic [`KEY_W-1:0] op_b;
    logic [`KEY_W-1:0] result_data;
    logic              result_valid;
    logic              task_end;
    logic              busy;
    logic [31:0]       error_count;
    logic [31:0]       result_count;
    logic [31:0]       cross_count;

    integer      seed;
    int          tb_errors;
    int          got_count;
    logic [31:0] batch_a [`BATCH_LEN];
    logic [31:0] batch_b [`BATCH_LEN];
    logic [31:0] batch_res [`BATCH_LEN];
    logic [31:0] cipher [`BATCH_LEN];

    paillier_top paillier_top_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .task_cmd     (task_cmd),
        .task_req     (task_req),
        .op_valid     (op_valid),
        .op_a         (op_a),
        .op_b         (op_b),
        .result_data  (result_data),
        .result_valid (result_valid),
        .task_end     (task_end),
        .busy         (busy)
    );

    tb_checker tb_checker_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .task_cmd     (task_cmd),
        .task_req     (task_req),
        .op_valid     (op_valid),
        .op_a         (op_a),
        .op_b         (op_b),
        .result_data  (result_data),
        .result_valid (result_valid),
        .task_end     (task_end),
        .busy         (busy),
        .error_count  (error_count),
        .result_count (result_count),
        .cross_count  (cross_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] draw_below(input logic [31:0] bound);
        logic [31:0] raw;
        raw = $random(seed);
        return raw % bound;
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic fill_encrypt();
        int i;
        for (i = 0; i < `BATCH_LEN; i++) begin
            batch_a[i] = draw_below(`MOD_N);
            batch_b[i] = draw_below(`MOD_N2);
        end
    endtask

    task automatic fill_ciphertexts();
        int i;
        for (i = 0; i < `BATCH_LEN; i++) begin
            batch_a[i] = draw_below(`MOD_N2);
            batch_b[i] = draw_below(`MOD_N2);
        end
    endtask

    // neighbours of the first encryption batch
    task automatic fill_from_cipher();
        int i;
        for (i = 0; i < `BATCH_LEN; i++) begin
            batch_a[i] = cipher[i];
            batch_b[i] = cipher[(i + 1) % `BATCH_LEN];
        end
    endtask

    // k = 0 and k = 1 first, then random exponents
    task automatic fill_scalar();
        int i;
        for (i = 0; i < `BATCH_LEN; i++) begin
            batch_a[i] = draw_below(`MOD_N2);
            batch_b[i] = (i < 2) ? 32'(i) : draw_below(`MOD_N2);
        end
    endtask

    task automatic send_operands(input bit with_gaps);
        int i;
        int gap;
        for (i = 0; i < `BATCH_LEN; i++) begin
            op_valid = 1'b1;
            op_a     = batch_a[i];
            op_b     = batch_b[i];
            @(posedge clk);
            #1;
            op_valid = 1'b0;
            if (with_gaps) begin
                gap = draw_below(32'd4);
                repeat (gap) begin
                    @(posedge clk);
                    #1;
                end
            end
        end
    endtask

    task automatic collect_results();
        bit done;
        done      = 1'b0;
        got_count = 0;
        while (!done) begin
            @(posedge clk);
            if (result_valid) begin
                if (got_count < `BATCH_LEN) begin
                    batch_res[got_count] = result_data;
                end
                got_count++;
                done = task_end;
            end
        end
    endtask

    task automatic run_task(input task_cmd_e cmd, input bit with_gaps, input string name);
        @(posedge clk);
        #1;
        task_cmd = cmd;
        task_req = 1'b1;
        @(posedge clk);
        #1;
        task_req = 1'b0;
        fork
            send_operands(with_gaps);
            collect_results();
        join
        if (got_count != `BATCH_LEN) begin
            $display("mismatch %s results expected %0d actual %0d", name, `BATCH_LEN, got_count);
            tb_errors++;
        end
        wait_cycles(4);
    endtask

    initial begin
        seed      = 32'h2b401a77;
        tb_errors = 0;
        rst_n     = 1'b0;
        task_cmd  = 2'b00;
        task_req  = 1'b0;
        op_valid  = 1'b0;
        op_a      = '0;
        op_b      = '0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        wait_cycles(3);

        fill_encrypt();
        run_task(cmd_encrypt, 1'b0, "encrypt_burst");
        for (int i = 0; i < `BATCH_LEN; i++) begin
            cipher[i] = batch_res[i];
        end
        fill_ciphertexts();
        run_task(cmd_homo_add, 1'b1, "homo_add_random");
        fill_from_cipher();
        run_task(cmd_homo_add, 1'b0, "homo_add_of_encrypt");
        fill_scalar();
        run_task(cmd_scalar_mul, 1'b1, "scalar_mul");
        fill_encrypt();
        run_task(cmd_encrypt, 1'b1, "encrypt_gaps");
        wait_cycles(10);

        if (cross_count != `BATCH_LEN) begin
            $display("mismatch homo_cross checks expected %0d actual %0d", `BATCH_LEN, cross_count);
            tb_errors++;
        end
        if (result_count != NUM_TASKS * `BATCH_LEN) begin
            $display("mismatch total results expected %0d actual %0d",
                     NUM_TASKS * `BATCH_LEN, result_count);
            tb_errors++;
        end
        $display("errors: checker %0d, testbench %0d, results seen %0d",
                 error_count, tb_errors, result_count);
        if (error_count == 0 && tb_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // limit scales with task count and worst item latency
    initial begin
        #(TIMEOUT_NS);
        $display("the run timed out after %0d ns without finishing all tasks", TIMEOUT_NS);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// File: source/mod_exp.sv
`timescale 1ns/1ps
`include "paillier_defs.svh"

module mod_exp (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                exp_start,
    input  paillier_pkg::word_t exp_base,
    input  paillier_pkg::word_t exp_power,
    output paillier_pkg::word_t exp_result,
    output logic                exp_done
);
    import paillier_pkg::*;

    typedef enum logic [1:0] {
        ex_idle,
        ex_scan,
        ex_sq,
        ex_mul
    } exp_state_e;

    localparam int CW = $clog2(`KEY_W + 1);

    exp_state_e    state_q;
    word_t         base_q;
    word_t         pow_q;
    word_t         acc_q;
    logic [CW-1:0] bits_q;
    logic          issued_q;
    logic          start_q;
    logic          done_q;
    logic          last_bit;

    mod_mul_if mm_i ();

    mod_mul mod_mul_i (
        .clk   (clk),
        .rst_n (rst_n),
        .mm    (mm_i.server)
    );

    // square uses acc twice, multiply uses acc and the base
    assign mm_i.start = start_q;
    assign mm_i.a     = acc_q;
    assign mm_i.b     = (state_q == ex_mul) ? base_q : acc_q;

    // bits_q counts the bits left, including the current msb of pow_q
    assign last_bit = (bits_q == CW'(1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= ex_idle;
            bits_q   <= '0;
            issued_q <= 1'b0;
            start_q  <= 1'b0;
            done_q   <= 1'b0;
        end else begin
            start_q <= 1'b0;
            done_q  <= 1'b0;
            case (state_q)
                ex_idle: begin
                    if (exp_start) begin
                        bits_q <= CW'(`KEY_W);
                        if (exp_power == '0) begin
                            done_q <= 1'b1;
                        end else begin
                            state_q <= ex_scan;
                        end
                    end
                end
                // leading zeros
                ex_scan: begin
                    bits_q <= bits_q - 1'b1;
                    if (pow_q[`KEY_W-1]) begin
                        issued_q <= 1'b0;
                        if (last_bit) begin
                            done_q  <= 1'b1;
                            state_q <= ex_idle;
                        end else begin
                            state_q <= ex_sq;
                        end
                    end
                end
                ex_sq, ex_mul: begin
                    if (!issued_q) begin
                        start_q  <= 1'b1;
                        issued_q <= 1'b1;
                    end
                    if (mm_i.done) begin
                        issued_q <= 1'b0;
                        if (state_q == ex_sq && pow_q[`KEY_W-1]) begin
                            state_q <= ex_mul;
                        end else begin
                            bits_q <= bits_q - 1'b1;
                            if (last_bit) begin
                                done_q  <= 1'b1;
                                state_q <= ex_idle;
                            end else begin
                                state_q <= ex_sq;
                            end
                        end
                    end
                end
                default: state_q <= ex_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state_q)
            ex_idle: begin
                if (exp_start) begin
                    base_q <= (exp_base >= `MOD_N2) ? exp_base - `MOD_N2 : exp_base;
                    pow_q  <= exp_power;
                    acc_q  <= word_t'(1);
                end
            end
            ex_scan: begin
                pow_q <= pow_q << 1;
                // first set bit, 1^2 * base
                if (pow_q[`KEY_W-1]) begin
                    acc_q <= base_q;
                end
            end
            ex_sq: begin
                if (mm_i.done) begin
                    acc_q <= mm_i.product;
                    if (!pow_q[`KEY_W-1]) begin
                        pow_q <= pow_q << 1;
                    end
                end
            end
            ex_mul: begin
                if (mm_i.done) begin
                    acc_q <= mm_i.product;
                    pow_q <= pow_q << 1;
                end
            end
            default: ;
        endcase
    end

    assign exp_result = acc_q;
    assign exp_done   = done_q;

endmodule

// File: source/mod_mul.sv
`timescale 1ns/1ps
`include "paillier_defs.svh"

module mod_mul (
    input  logic      clk,
    input  logic      rst_n,
    mod_mul_if.server mm
);
    import paillier_pkg::*;

    localparam int CW = $clog2(`KEY_W + 1);
    localparam logic [`KEY_W:0] MOD_EXT = {1'b0, `MOD_N2};

    word_t          a_q;
    word_t          b_q;
    word_t          acc_q;
    word_t          a_in;
    logic [CW-1:0]  cnt_q;
    logic           busy_q;
    logic           done_q;
    logic [`KEY_W:0] dbl;
    logic [`KEY_W:0] dbl_red;
    logic [`KEY_W:0] sum;
    logic [`KEY_W:0] sum_red;

    // any 32-bit value is below 2*n^2, one subtraction is enough
    assign a_in = (mm.a >= `MOD_N2) ? mm.a - `MOD_N2 : mm.a;

    // one step: acc = 2*acc (+ a) mod n^2
    always_comb begin
        dbl     = {acc_q, 1'b0};
        dbl_red = (dbl >= MOD_EXT) ? dbl - MOD_EXT : dbl;
        sum     = dbl_red + (b_q[`KEY_W-1] ? {1'b0, a_q} : '0);
        sum_red = (sum >= MOD_EXT) ? sum - MOD_EXT : sum;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end else begin
            done_q <= 1'b0;
            if (mm.start) begin
                busy_q <= 1'b1;
                cnt_q  <= CW'(`KEY_W);
            end else if (busy_q) begin
                cnt_q <= cnt_q - 1'b1;
                if (cnt_q == CW'(1)) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    // msb of b first
    always_ff @(posedge clk) begin
        if (mm.start) begin
            a_q   <= a_in;
            b_q   <= mm.b;
            acc_q <= '0;
        end else if (busy_q) begin
            acc_q <= sum_red[`KEY_W-1:0];
            b_q   <= b_q << 1;
        end
    end

    assign mm.product = acc_q;
    assign mm.done    = done_q;

    // requester has to wait for done before the next start
    a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        mm.start |-> !busy_q);

endmodule

// File: source/mod_mul_if.sv
`timescale 1ns/1ps

interface mod_mul_if;
    import paillier_pkg::*;

    // a and b are sampled in the start cycle
    logic  start;
    word_t a;
    word_t b;
    // product is valid only while done is high
    word_t product;
    logic  done;

    modport requester (
        output start,
        output a,
        output b,
        input  product,
        input  done
    );

    modport server (
        input  start,
        input  a,
        input  b,
        output product,
        output done
    );

endinterface

// File: source/operand_buffer.sv
`timescale 1ns/1ps
`include "paillier_defs.svh"

module operand_buffer (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        clear,
    input  logic                        wr_valid,
    input  paillier_pkg::operand_pair_t wr_pair,
    input  logic [`BATCH_AW-1:0]        rd_index,
    output paillier_pkg::operand_pair_t rd_pair,
    output logic [`BATCH_AW:0]          wr_count
);
    import paillier_pkg::*;

    operand_pair_t        mem [`BATCH_LEN];
    logic [`BATCH_AW-1:0] wr_addr;

    // a write in the clear cycle lands at slot 0
    assign wr_addr = clear ? '0 : wr_count[`BATCH_AW-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_count <= '0;
        end else if (clear) begin
            wr_count <= {{`BATCH_AW{1'b0}}, wr_valid};
        end else if (wr_valid) begin
            wr_count <= wr_count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_valid) begin
            mem[wr_addr] <= wr_pair;
        end
    end

    assign rd_pair = mem[rd_index];

    // more than BATCH_LEN pairs in one task would overwrite unread items
    a_not_full: assert property (@(posedge clk) disable iff (!rst_n)
        (wr_valid && !clear) |-> (wr_count < (`BATCH_AW+1)'(`BATCH_LEN)));

endmodule

// File: source/paillier_defs.svh
`ifndef PAILLIER_DEFS_SVH
`define PAILLIER_DEFS_SVH

// datapath word, wide enough for residues modulo n squared
`define KEY_W 32

// public key, n = 251 * 241
`define MOD_N 32'd60491

// n squared
`define MOD_N2 32'd3659161081

// items per task and buffer addressing
`define BATCH_LEN 8
`define BATCH_AW 3

`endif

// File: source/paillier_pkg.sv
`include "paillier_defs.svh"

package paillier_pkg;

    // one residue modulo n^2
    typedef logic [`KEY_W-1:0] word_t;

    typedef struct packed {
        word_t a;
        word_t b;
    } operand_pair_t;

    typedef enum logic [1:0] {
        cmd_encrypt    = 2'b00,
        cmd_reserved   = 2'b01,
        cmd_homo_add   = 2'b10,
        cmd_scalar_mul = 2'b11
    } task_cmd_e;

    typedef enum logic [2:0] {
        st_idle,
        st_fetch,
        st_enc_mn,
        st_enc_rn,
        st_enc_mul,
        st_add,
        st_scalar,
        st_emit
    } ctrl_state_e;

endpackage

// File: source/paillier_top.sv
`timescale 1ns/1ps
`include "paillier_defs.svh"

module paillier_top (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [1:0]        task_cmd,
    input  logic              task_req,
    input  logic              op_valid,
    input  logic [`KEY_W-1:0] op_a,
    input  logic [`KEY_W-1:0] op_b,
    output logic [`KEY_W-1:0] result_data,
    output logic              result_valid,
    output logic              task_end,
    output logic              busy
);
    import paillier_pkg::*;

    operand_pair_t        wr_pair;
    operand_pair_t        rd_pair;
    logic [`BATCH_AW-1:0] rd_index;
    logic [`BATCH_AW:0]   wr_count;
    logic                 buf_clear;
    logic                 exp_start;
    word_t                exp_base;
    word_t                exp_power;
    word_t                exp_result;
    logic                 exp_done;

    mod_mul_if mm_i ();

    assign wr_pair = '{a: op_a, b: op_b};

    task_ctrl task_ctrl_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .task_req     (task_req),
        .task_cmd     (task_cmd_e'(task_cmd)),
        .buf_clear    (buf_clear),
        .rd_index     (rd_index),
        .rd_pair      (rd_pair),
        .wr_count     (wr_count),
        .mm           (mm_i.requester),
        .exp_start    (exp_start),
        .exp_base     (exp_base),
        .exp_power    (exp_power),
        .exp_result   (exp_result),
        .exp_done     (exp_done),
        .result_data  (result_data),
        .result_valid (result_valid),
        .task_end     (task_end),
        .busy         (busy)
    );

    operand_buffer operand_buffer_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .clear    (buf_clear),
        .wr_valid (op_valid),
        .wr_pair  (wr_pair),
        .rd_index (rd_index),
        .rd_pair  (rd_pair),
        .wr_count (wr_count)
    );

    mod_exp mod_exp_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .exp_start  (exp_start),
        .exp_base   (exp_base),
        .exp_power  (exp_power),
        .exp_result (exp_result),
        .exp_done   (exp_done)
    );

    mod_mul mod_mul_i (
        .clk   (clk),
        .rst_n (rst_n),
        .mm    (mm_i.server)
    );

endmodule

// File: source/task_ctrl.sv
`timescale 1ns/1ps
`include "paillier_defs.svh"

module task_ctrl (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        task_req,
    input  paillier_pkg::task_cmd_e     task_cmd,
    output logic                        buf_clear,
    output logic [`BATCH_AW-1:0]        rd_index,
    input  paillier_pkg::operand_pair_t rd_pair,
    input  logic [`BATCH_AW:0]          wr_count,
    mod_mul_if.requester                mm,
    output logic                        exp_start,
    output paillier_pkg::word_t         exp_base,
    output paillier_pkg::word_t         exp_power,
    input  paillier_pkg::word_t         exp_result,
    input  logic                        exp_done,
    output paillier_pkg::word_t         result_data,
    output logic                        result_valid,
    output logic                        task_end,
    output logic                        busy
);
    import paillier_pkg::*;

    ctrl_state_e        state_q;
    task_cmd_e          cmd_q;
    logic [`BATCH_AW:0] item_q;
    logic               mm_start_q;
    logic               exp_start_q;
    word_t              mn_q;
    word_t              res_q;
    logic               have_item;
    logic               last_item;

    assign have_item = (wr_count > item_q);
    assign last_item = (item_q == (`BATCH_AW+1)'(`BATCH_LEN - 1));
    assign rd_index  = item_q[`BATCH_AW-1:0];
    assign buf_clear = (state_q == st_idle) && task_req;

    // operand select, rd_pair holds still while an item is in flight
    always_comb begin
        case (state_q)
            st_enc_mn: begin
                mm.a = rd_pair.a;
                mm.b = `MOD_N;
            end
            st_enc_mul: begin
                mm.a = mn_q;
                mm.b = res_q;
            end
            default: begin
                mm.a = rd_pair.a;
                mm.b = rd_pair.b;
            end
        endcase
    end
    assign mm.start = mm_start_q;

    // r^n for encryption, c^k for scalar multiplication
    assign exp_start = exp_start_q;
    assign exp_base  = (cmd_q == cmd_encrypt) ? rd_pair.b : rd_pair.a;
    assign exp_power = (cmd_q == cmd_encrypt) ? `MOD_N : rd_pair.b;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q     <= st_idle;
            cmd_q       <= cmd_encrypt;
            item_q      <= '0;
            mm_start_q  <= 1'b0;
            exp_start_q <= 1'b0;
        end else begin
            mm_start_q  <= 1'b0;
            exp_start_q <= 1'b0;
            case (state_q)
                st_idle: begin
                    if (task_req) begin
                        cmd_q   <= task_cmd;
                        item_q  <= '0;
                        state_q <= st_fetch;
                    end
                end
                st_fetch: begin
                    if (have_item) begin
                        case (cmd_q)
                            cmd_encrypt: begin
                                mm_start_q <= 1'b1;
                                state_q    <= st_enc_mn;
                            end
                            cmd_homo_add: begin
                                mm_start_q <= 1'b1;
                                state_q    <= st_add;
                            end
                            cmd_scalar_mul: begin
                                exp_start_q <= 1'b1;
                                state_q     <= st_scalar;
                            end
                            // reserved code, emit zero so the batch still drains
                            default: state_q <= st_emit;
                        endcase
                    end
                end
                st_enc_mn: begin
                    if (mm.done) begin
                        exp_start_q <= 1'b1;
                        state_q     <= st_enc_rn;
                    end
                end
                st_enc_rn: begin
                    if (exp_done) begin
                        mm_start_q <= 1'b1;
                        state_q    <= st_enc_mul;
                    end
                end
                st_enc_mul, st_add: begin
                    if (mm.done) begin
                        state_q <= st_emit;
                    end
                end
                st_scalar: begin
                    if (exp_done) begin
                        state_q <= st_emit;
                    end
                end
                st_emit: begin
                    item_q  <= item_q + 1'b1;
                    state_q <= last_item ? st_idle : st_fetch;
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        // m*n mod n^2 is a multiple of n, so +1 never wraps
        if (state_q == st_enc_mn && mm.done) begin
            mn_q <= mm.product + 1'b1;
        end
        if ((state_q == st_enc_rn || state_q == st_scalar) && exp_done) begin
            res_q <= exp_result;
        end else if ((state_q == st_enc_mul || state_q == st_add) && mm.done) begin
            res_q <= mm.product;
        end else if (state_q == st_fetch && have_item && cmd_q == cmd_reserved) begin
            res_q <= '0;
        end
    end

    assign result_data  = res_q;
    assign result_valid = (state_q == st_emit);
    assign task_end     = result_valid && last_item;
    assign busy         = (state_q != st_idle);

    a_req_idle: assert property (@(posedge clk) disable iff (!rst_n)
        task_req |-> !busy);

    // decryption code has no datapath
    a_cmd_legal: assert property (@(posedge clk) disable iff (!rst_n)
        task_req |-> (task_cmd != cmd_reserved));

endmodule
